// File: Bender.yml
package:
  name: line_xfer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/line_xfer_pkg.sv
      - rtl/line_req_arbiter.sv
      - rtl/cache_line_xfer.sv
      - rtl/axi_burst_rw.sv
      - rtl/line_xfer_top.sv
      - target: simulation
        files:
          - sim/axi_mem_slave.sv
          - sim/tb_line_xfer.sv

// File: all.f
+incdir+include
rtl/line_xfer_pkg.sv
rtl/line_req_arbiter.sv
rtl/cache_line_xfer.sv
rtl/axi_burst_rw.sv
rtl/line_xfer_top.sv
sim/axi_mem_slave.sv
sim/tb_line_xfer.sv

// File: include/line_xfer_defines.svh
// AXI size and burst type codes used by the line burst engine and memory model
`ifndef LINE_XFER_DEFINES_SVH
`define LINE_XFER_DEFINES_SVH

// size codes, log2 of bytes per beat
`define SIZE_B 3'b000
`define SIZE_H 3'b001
`define SIZE_W 3'b010
`define SIZE_D 3'b011

// burst type codes
`define BURST_FIXED 2'b00
`define BURST_INCR  2'b01
`define BURST_WRAP  2'b10

`endif

// File: rtl/axi_burst_rw.sv
// AXI line burst engine
// turns one 512-bit line into an eight-beat INCR burst of 64-bit beats,
// read data is collected into a line register
`timescale 1ns/1ns

`include "line_xfer_defines.svh"

module axi_burst_rw #(
  parameter int ADDR_W = line_xfer_pkg::addr_w
) (
  input  logic                              clk,
  input  logic                              rst,
  // line side
  input  logic                              i_line_valid,
  output logic                              o_line_ready,
  input  logic                              i_line_op,
  input  logic [ADDR_W-1:0]                 i_line_addr,
  input  logic [line_xfer_pkg::line_w-1:0]  i_line_wdata,
  output logic [line_xfer_pkg::line_w-1:0]  o_line_rdata,
  // read address
  output logic                              o_ar_valid,
  input  logic                              i_ar_ready,
  output logic [ADDR_W-1:0]                 o_ar_addr,
  output logic [7:0]                        o_ar_len,
  output logic [2:0]                        o_ar_size,
  output logic [1:0]                        o_ar_burst,
  // read data
  input  logic                              i_r_valid,
  output logic                              o_r_ready,
  input  logic [line_xfer_pkg::beat_w-1:0]  i_r_data,
  input  logic                              i_r_last,
  // write address
  output logic                              o_aw_valid,
  input  logic                              i_aw_ready,
  output logic [ADDR_W-1:0]                 o_aw_addr,
  output logic [7:0]                        o_aw_len,
  output logic [2:0]                        o_aw_size,
  output logic [1:0]                        o_aw_burst,
  // write data
  output logic                              o_w_valid,
  input  logic                              i_w_ready,
  output logic [line_xfer_pkg::beat_w-1:0]  o_w_data,
  output logic [line_xfer_pkg::beat_w/8-1:0] o_w_strb,
  output logic                              o_w_last,
  // write response
  input  logic                              i_b_valid,
  output logic                              o_b_ready
);
  import line_xfer_pkg::*;

  localparam int unsigned cnt_w = $clog2(beats_per_line);
  localparam logic [cnt_w-1:0] last_beat = cnt_w'(beats_per_line - 1);

  // fsm states
  localparam logic [2:0] st_idle = 3'd0;
  localparam logic [2:0] st_addr = 3'd1;
  localparam logic [2:0] st_data = 3'd2;
  localparam logic [2:0] st_resp = 3'd3;
  localparam logic [2:0] st_done = 3'd4;

  logic [2:0]       state;
  logic [cnt_w-1:0] beat_cnt;
  logic [line_w-1:0] rd_line;
  logic             is_wr;

  // line inputs stay stable until line_ready, no local copy
  assign is_wr = (i_line_op == op_write);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      beat_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (i_line_valid) begin
            state    <= st_addr;
            beat_cnt <= '0;
          end
        end
        st_addr: begin
          // ar or aw accepted
          if ((o_ar_valid && i_ar_ready) || (o_aw_valid && i_aw_ready)) begin
            state <= st_data;
          end
        end
        st_data: begin
          if (!is_wr && i_r_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (i_r_last) begin
              state <= st_done;
            end
          end else if (o_w_valid && i_w_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (o_w_last) begin
              state <= st_resp;
            end
          end
        end
        st_resp: begin
          if (i_b_valid) begin
            state <= st_done;
          end
        end
        default: begin
          // st_done, line_ready pulse
          state <= st_idle;
        end
      endcase
    end
  end

  // read beats shift in from the top, beat n ends at bits 64n up
  always_ff @(posedge clk) begin
    if (state == st_data && !is_wr && i_r_valid) begin
      rd_line <= {i_r_data, rd_line[line_w-1:beat_w]};
    end
  end

  assign o_line_rdata = rd_line;
  assign o_line_ready = (state == st_done);

  // read address channel
  assign o_ar_valid = (state == st_addr) & ~is_wr;
  assign o_ar_addr  = i_line_addr;
  assign o_ar_len   = 8'(beats_per_line - 1);
  assign o_ar_size  = `SIZE_D;
  assign o_ar_burst = `BURST_INCR;

  // r ready tied high, stalls come from the slave only
  assign o_r_ready = 1'b1;

  // write address channel
  assign o_aw_valid = (state == st_addr) & is_wr;
  assign o_aw_addr  = i_line_addr;
  assign o_aw_len   = 8'(beats_per_line - 1);
  assign o_aw_size  = `SIZE_D;
  assign o_aw_burst = `BURST_INCR;

  // write beats picked from the held line
  assign o_w_valid = (state == st_data) & is_wr;
  assign o_w_data  = i_line_wdata[beat_cnt*beat_w +: beat_w];
  assign o_w_strb  = '1;
  assign o_w_last  = (beat_cnt == last_beat);

  assign o_b_ready = (state == st_resp);

  // slave marks last on the eighth beat only
  ap_r_last_beat: assert property (@(posedge clk) disable iff (rst)
    i_r_valid && o_r_ready && i_r_last |-> beat_cnt == last_beat);

  // a stalled address keeps valid and payload
  ap_ar_hold: assert property (@(posedge clk) disable iff (rst)
    o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar_addr));

endmodule

// File: rtl/cache_line_xfer.sv
// Cache line transfer unit
// starts a line transfer once the request is seen two cycles in a row,
// aligns the address to the line and returns a one-cycle ack
`timescale 1ns/1ns

module cache_line_xfer #(
  parameter int ADDR_W = line_xfer_pkg::addr_w
) (
  input  logic                              clk,
  input  logic                              rst,
  // requester side
  input  logic                              i_req,
  input  logic                              i_op,
  input  logic [ADDR_W-1:0]                 i_addr,
  input  logic [line_xfer_pkg::line_w-1:0]  i_wdata,
  output logic [line_xfer_pkg::line_w-1:0]  o_rdata,
  output logic                              o_ack,
  // burst engine side
  output logic                              o_line_valid,
  input  logic                              i_line_ready,
  output logic                              o_line_op,
  output logic [ADDR_W-1:0]                 o_line_addr,
  output logic [line_xfer_pkg::line_w-1:0]  o_line_wdata,
  input  logic [line_xfer_pkg::line_w-1:0]  i_line_rdata
);
  import line_xfer_pkg::*;

  // request seen last cycle
  logic req_his;
  logic start;
  logic hs;

  // line handshake with the burst engine
  assign hs = o_line_valid & i_line_ready;

  // two-cycle request outside the ack cycle of the previous line
  assign start = i_req & req_his & ~o_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_his      <= 1'b0;
      o_ack        <= 1'b0;
      o_line_valid <= 1'b0;
    end else begin
      req_his <= i_req;
      // ack one cycle after the handshake
      o_ack   <= hs;
      if (hs) begin
        o_line_valid <= 1'b0;
      end else if (start) begin
        o_line_valid <= 1'b1;
      end
    end
  end

  // line aligned start address
  assign o_line_addr = {i_addr[ADDR_W-1:line_off_w], {line_off_w{1'b0}}};

  // op and data pass straight through
  assign o_line_op    = i_op;
  assign o_line_wdata = i_wdata;
  assign o_rdata      = i_line_rdata;

  // valid only drops on a handshake
  ap_valid_hold: assert property (@(posedge clk) disable iff (rst)
    o_line_valid && !i_line_ready |=> o_line_valid);

  // ready pulse only answers a held line
  ap_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
    i_line_ready |-> o_line_valid);

endmodule

// File: rtl/line_req_arbiter.sv
// Line request arbiter
// round-robin pick between icache and dcache line requests,
// holds the grant until ack and routes ack and read data back to the owner
`timescale 1ns/1ns

module line_req_arbiter #(
  parameter int ADDR_W = line_xfer_pkg::addr_w
) (
  input  logic                              clk,
  input  logic                              rst,
  // instruction cache, refill only
  input  logic                              i_ic_req,
  input  logic [ADDR_W-1:0]                 i_ic_addr,
  output logic                              o_ic_ack,
  output logic [line_xfer_pkg::line_w-1:0]  o_ic_rdata,
  // data cache, refill and writeback
  input  logic                              i_dc_req,
  input  logic                              i_dc_op,
  input  logic [ADDR_W-1:0]                 i_dc_addr,
  input  logic [line_xfer_pkg::line_w-1:0]  i_dc_wdata,
  output logic                              o_dc_ack,
  output logic [line_xfer_pkg::line_w-1:0]  o_dc_rdata,
  // toward the transfer unit
  output logic                              o_req,
  output logic                              o_op,
  output logic [ADDR_W-1:0]                 o_addr,
  output logic [line_xfer_pkg::line_w-1:0]  o_wdata,
  input  logic                              i_ack,
  input  logic [line_xfer_pkg::line_w-1:0]  i_rdata
);
  import line_xfer_pkg::*;

  // grant held from pick until ack
  logic    locked;
  // single idle cycle after each ack
  logic    gap;
  // current owner, doubles as the last-served pointer
  req_id_t owner;
  req_id_t pick;

  // both asking, so the one not served last wins
  always_comb begin
    if (i_ic_req && i_dc_req) begin
      pick = ~owner;
    end else if (i_dc_req) begin
      pick = req_dcache;
    end else begin
      pick = req_icache;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked <= 1'b0;
      gap    <= 1'b0;
      // last served = dcache, so icache goes first
      owner  <= req_dcache;
    end else begin
      gap <= 1'b0;
      if (locked) begin
        if (i_ack) begin
          locked <= 1'b0;
          gap    <= 1'b1;
        end
      end else if (!gap && (i_ic_req || i_dc_req)) begin
        locked <= 1'b1;
        owner  <= pick;
      end
    end
  end

  // owner's request toward the transfer unit
  assign o_req   = locked;
  // icache never writes
  assign o_op    = (owner == req_dcache) ? i_dc_op : op_read;
  assign o_addr  = (owner == req_dcache) ? i_dc_addr : i_ic_addr;
  assign o_wdata = (owner == req_dcache) ? i_dc_wdata : '0;

  // ack and data back to the owner only
  assign o_ic_ack   = i_ack & locked & (owner == req_icache);
  assign o_dc_ack   = i_ack & locked & (owner == req_dcache);
  assign o_ic_rdata = (owner == req_icache) ? i_rdata : '0;
  assign o_dc_rdata = (owner == req_dcache) ? i_rdata : '0;

  // at most one cache sees an ack
  ap_ack_excl: assert property (@(posedge clk) disable iff (rst)
    !(o_ic_ack && o_dc_ack));

  // request drops right after ack so the start filter sees a gap
  ap_gap_after_ack: assert property (@(posedge clk) disable iff (rst)
    i_ack |=> !o_req);

endmodule

// File: rtl/line_xfer_pkg.sv
// Line transfer package
// widths, cache line geometry, requester ids and operation codes
package line_xfer_pkg;

  // byte address width of the cache side
  localparam int unsigned addr_w = 32;

  // one cache line
  localparam int unsigned line_bytes = 64;
  localparam int unsigned line_w = line_bytes * 8;

  // memory bus beat
  localparam int unsigned beat_w = 64;
  localparam int unsigned beats_per_line = line_w / beat_w;

  // byte offset bits inside a line
  localparam int unsigned line_off_w = $clog2(line_bytes);

  // requester index, one bit for two caches
  typedef logic req_id_t;

  localparam req_id_t req_icache = 1'b0;
  localparam req_id_t req_dcache = 1'b1;

  // line operation
  localparam logic op_read  = 1'b0;
  localparam logic op_write = 1'b1;

endpackage

// File: rtl/line_xfer_top.sv
// Line transfer top level
// arbiter, cache line transfer unit and AXI burst engine in a chain
`timescale 1ns/1ns

module line_xfer_top #(
  parameter int ADDR_W = line_xfer_pkg::addr_w
) (
  input  logic                               clk,
  input  logic                               rst,
  // instruction cache
  input  logic                               i_ic_req,
  input  logic [ADDR_W-1:0]                  i_ic_addr,
  output logic                               o_ic_ack,
  output logic [line_xfer_pkg::line_w-1:0]   o_ic_rdata,
  // data cache
  input  logic                               i_dc_req,
  input  logic                               i_dc_op,
  input  logic [ADDR_W-1:0]                  i_dc_addr,
  input  logic [line_xfer_pkg::line_w-1:0]   i_dc_wdata,
  output logic                               o_dc_ack,
  output logic [line_xfer_pkg::line_w-1:0]   o_dc_rdata,
  // AXI read
  output logic                               o_ar_valid,
  input  logic                               i_ar_ready,
  output logic [ADDR_W-1:0]                  o_ar_addr,
  output logic [7:0]                         o_ar_len,
  output logic [2:0]                         o_ar_size,
  output logic [1:0]                         o_ar_burst,
  input  logic                               i_r_valid,
  output logic                               o_r_ready,
  input  logic [line_xfer_pkg::beat_w-1:0]   i_r_data,
  input  logic                               i_r_last,
  // AXI write
  output logic                               o_aw_valid,
  input  logic                               i_aw_ready,
  output logic [ADDR_W-1:0]                  o_aw_addr,
  output logic [7:0]                         o_aw_len,
  output logic [2:0]                         o_aw_size,
  output logic [1:0]                         o_aw_burst,
  output logic                               o_w_valid,
  input  logic                               i_w_ready,
  output logic [line_xfer_pkg::beat_w-1:0]   o_w_data,
  output logic [line_xfer_pkg::beat_w/8-1:0] o_w_strb,
  output logic                               o_w_last,
  input  logic                               i_b_valid,
  output logic                               o_b_ready
);
  import line_xfer_pkg::*;

  // arbiter to transfer unit
  logic              arb_req;
  logic              arb_op;
  logic [ADDR_W-1:0] arb_addr;
  logic [line_w-1:0] arb_wdata;
  logic              xfer_ack;
  logic [line_w-1:0] xfer_rdata;

  // transfer unit to burst engine
  logic              line_valid;
  logic              line_ready;
  logic              line_op;
  logic [ADDR_W-1:0] line_addr;
  logic [line_w-1:0] line_wdata;
  logic [line_w-1:0] line_rdata;

  line_req_arbiter #(.ADDR_W(ADDR_W)) i_arbiter (
    .clk        (clk),
    .rst        (rst),
    .i_ic_req   (i_ic_req),
    .i_ic_addr  (i_ic_addr),
    .o_ic_ack   (o_ic_ack),
    .o_ic_rdata (o_ic_rdata),
    .i_dc_req   (i_dc_req),
    .i_dc_op    (i_dc_op),
    .i_dc_addr  (i_dc_addr),
    .i_dc_wdata (i_dc_wdata),
    .o_dc_ack   (o_dc_ack),
    .o_dc_rdata (o_dc_rdata),
    .o_req      (arb_req),
    .o_op       (arb_op),
    .o_addr     (arb_addr),
    .o_wdata    (arb_wdata),
    .i_ack      (xfer_ack),
    .i_rdata    (xfer_rdata)
  );

  cache_line_xfer #(.ADDR_W(ADDR_W)) i_xfer (
    .clk          (clk),
    .rst          (rst),
    .i_req        (arb_req),
    .i_op         (arb_op),
    .i_addr       (arb_addr),
    .i_wdata      (arb_wdata),
    .o_rdata      (xfer_rdata),
    .o_ack        (xfer_ack),
    .o_line_valid (line_valid),
    .i_line_ready (line_ready),
    .o_line_op    (line_op),
    .o_line_addr  (line_addr),
    .o_line_wdata (line_wdata),
    .i_line_rdata (line_rdata)
  );

  axi_burst_rw #(.ADDR_W(ADDR_W)) i_burst (
    .clk          (clk),
    .rst          (rst),
    .i_line_valid (line_valid),
    .o_line_ready (line_ready),
    .i_line_op    (line_op),
    .i_line_addr  (line_addr),
    .i_line_wdata (line_wdata),
    .o_line_rdata (line_rdata),
    .o_ar_valid   (o_ar_valid),
    .i_ar_ready   (i_ar_ready),
    .o_ar_addr    (o_ar_addr),
    .o_ar_len     (o_ar_len),
    .o_ar_size    (o_ar_size),
    .o_ar_burst   (o_ar_burst),
    .i_r_valid    (i_r_valid),
    .o_r_ready    (o_r_ready),
    .i_r_data     (i_r_data),
    .i_r_last     (i_r_last),
    .o_aw_valid   (o_aw_valid),
    .i_aw_ready   (i_aw_ready),
    .o_aw_addr    (o_aw_addr),
    .o_aw_len     (o_aw_len),
    .o_aw_size    (o_aw_size),
    .o_aw_burst   (o_aw_burst),
    .o_w_valid    (o_w_valid),
    .i_w_ready    (i_w_ready),
    .o_w_data     (o_w_data),
    .o_w_strb     (o_w_strb),
    .o_w_last     (o_w_last),
    .i_b_valid    (i_b_valid),
    .o_b_ready    (o_b_ready)
  );

endmodule

// File: sim/axi_mem_slave.sv
// AXI memory slave model for the line transfer testbench
// 1024-line memory, random stalls on every ready and valid it drives,
// counts bursts and W beats and flags any burst that is not 8 x 8-byte INCR
`timescale 1ns/1ns

`include "line_xfer_defines.svh"

module axi_mem_slave #(
  parameter int ADDR_W = line_xfer_pkg::addr_w,
  parameter int SEED   = 1
) (
  input  logic                               clk,
  input  logic                               rst,
  // read address and data
  input  logic                               i_ar_valid,
  output logic                               o_ar_ready,
  input  logic [ADDR_W-1:0]                  i_ar_addr,
  input  logic [7:0]                         i_ar_len,
  input  logic [2:0]                         i_ar_size,
  input  logic [1:0]                         i_ar_burst,
  output logic                               o_r_valid,
  input  logic                               i_r_ready,
  output logic [line_xfer_pkg::beat_w-1:0]   o_r_data,
  output logic                               o_r_last,
  // write address, data and response
  input  logic                               i_aw_valid,
  output logic                               o_aw_ready,
  input  logic [ADDR_W-1:0]                  i_aw_addr,
  input  logic [7:0]                         i_aw_len,
  input  logic [2:0]                         i_aw_size,
  input  logic [1:0]                         i_aw_burst,
  input  logic                               i_w_valid,
  output logic                               o_w_ready,
  input  logic [line_xfer_pkg::beat_w-1:0]   i_w_data,
  input  logic [line_xfer_pkg::beat_w/8-1:0] i_w_strb,
  input  logic                               i_w_last,
  output logic                               o_b_valid,
  input  logic                               i_b_ready,
  // statistics
  output int                                 o_ar_count,
  output int                                 o_aw_count,
  output int                                 o_w_beats,
  output int                                 o_fmt_errors
);
  import line_xfer_pkg::*;

  // line storage, filled by the testbench at time zero
  logic [line_w-1:0] mem [0:1023];

  integer            seed;
  logic              rd_active;
  logic              wr_active;
  logic              b_pend;
  logic [9:0]        rd_idx;
  logic [9:0]        wr_idx;
  logic [2:0]        rd_beat;
  logic [2:0]        wr_beat;
  logic              r_hs;
  logic              b_hs;
  logic [line_w-1:0] line_tmp;

  // three out of four cycles without a stall
  function automatic logic no_stall();
    return ($random(seed) & 3) != 0;
  endfunction

  task automatic check_burst_format(input string ch, input logic [7:0] len,
                                    input logic [2:0] size, input logic [1:0] burst);
    if (len != 8'd7 || size != `SIZE_D || burst != `BURST_INCR) begin
      o_fmt_errors++;
      $display("%0t ns: %s burst is len %0d size %0d type %0d, not an 8-beat INCR of 8 bytes",
               $time, ch, len, size, burst);
    end
  endtask

  initial begin
    seed         = SEED;
    o_ar_ready   = 1'b0;
    o_r_valid    = 1'b0;
    o_r_data     = '0;
    o_r_last     = 1'b0;
    o_aw_ready   = 1'b0;
    o_w_ready    = 1'b0;
    o_b_valid    = 1'b0;
    o_ar_count   = 0;
    o_aw_count   = 0;
    o_w_beats    = 0;
    o_fmt_errors = 0;
    rd_active    = 1'b0;
    wr_active    = 1'b0;
    b_pend       = 1'b0;
    rd_idx       = '0;
    wr_idx       = '0;
    rd_beat      = '0;
    wr_beat      = '0;
    forever begin
      @(posedge clk);
      // handshakes of the cycle that just ended
      r_hs = o_r_valid && i_r_ready;
      b_hs = o_b_valid && i_b_ready;
      if (rst) begin
        rd_active = 1'b0;
        wr_active = 1'b0;
        b_pend    = 1'b0;
      end else begin
        if (r_hs) begin
          if (rd_beat == 3'd7) begin
            rd_active = 1'b0;
          end
          rd_beat = rd_beat + 1'b1;
        end
        if (i_ar_valid && o_ar_ready) begin
          check_burst_format("AR", i_ar_len, i_ar_size, i_ar_burst);
          rd_idx    = i_ar_addr[line_off_w +: 10];
          rd_beat   = '0;
          rd_active = 1'b1;
          o_ar_count++;
        end
        if (i_w_valid && o_w_ready) begin
          line_tmp = mem[wr_idx];
          line_tmp[wr_beat*beat_w +: beat_w] = i_w_data;
          mem[wr_idx] = line_tmp;
          o_w_beats++;
          if (i_w_last != (wr_beat == 3'd7) || i_w_strb != '1) begin
            o_fmt_errors++;
            $display("%0t ns: W beat %0d has last %0b strb %h", $time, wr_beat, i_w_last,
                     i_w_strb);
          end
          // eighth beat closes the burst
          if (wr_beat == 3'd7) begin
            wr_active = 1'b0;
            b_pend    = 1'b1;
          end
          wr_beat = wr_beat + 1'b1;
        end
        if (b_hs) begin
          b_pend = 1'b0;
        end
        if (i_aw_valid && o_aw_ready) begin
          check_burst_format("AW", i_aw_len, i_aw_size, i_aw_burst);
          wr_idx    = i_aw_addr[line_off_w +: 10];
          wr_beat   = '0;
          wr_active = 1'b1;
          o_aw_count++;
        end
      end
      #2;
      if (rst) begin
        o_ar_ready = 1'b0;
        o_aw_ready = 1'b0;
        o_w_ready  = 1'b0;
        o_r_valid  = 1'b0;
        o_b_valid  = 1'b0;
      end else begin
        // one burst of each kind at a time
        o_ar_ready = !rd_active && no_stall();
        o_aw_ready = !wr_active && !b_pend && no_stall();
        o_w_ready  = wr_active && no_stall();
        // a raised valid holds until its handshake
        if (!(o_r_valid && !r_hs)) begin
          o_r_valid = rd_active && no_stall();
        end
        line_tmp = mem[rd_idx];
        o_r_data = line_tmp[rd_beat*beat_w +: beat_w];
        o_r_last = (rd_beat == 3'd7);
        if (!(o_b_valid && !b_hs)) begin
          o_b_valid = b_pend && no_stall();
        end
      end
    end
  end

endmodule

// File: sim/tb_line_xfer.sv
// Testbench for the cache line transfer path
// random icache and dcache line requests against a shadow memory model,
// memory slave with random back-pressure, per-test report and watchdog
`timescale 1ns/1ns

module tb_line_xfer;
  import line_xfer_pkg::*;

  localparam int ADDR_W     = addr_w;
  localparam int seed_init  = 71262;
  localparam int clk_period = 20;
  localparam int mem_lines  = 1024;
  localparam int n_refill   = 24;
  localparam int n_wback    = 24;
  localparam int n_reread   = 8;
  localparam int n_arb      = 16;
  localparam int total_reqs = n_refill + n_wback + n_reread + 2 * n_arb;

  logic              clk;
  logic              rst;
  logic              i_ic_req;
  logic [ADDR_W-1:0] i_ic_addr;
  logic              o_ic_ack;
  logic [line_w-1:0] o_ic_rdata;
  logic              i_dc_req;
  logic              i_dc_op;
  logic [ADDR_W-1:0] i_dc_addr;
  logic [line_w-1:0] i_dc_wdata;
  logic              o_dc_ack;
  logic [line_w-1:0] o_dc_rdata;
  // AXI between DUT and slave
  logic              ar_valid, ar_ready, r_valid, r_ready, r_last;
  logic              aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  logic [ADDR_W-1:0] ar_addr, aw_addr;
  logic [7:0]        ar_len, aw_len;
  logic [2:0]        ar_size, aw_size;
  logic [1:0]        ar_burst, aw_burst;
  logic [beat_w-1:0] r_data, w_data;
  logic [beat_w/8-1:0] w_strb;
  int                ar_count, aw_count, w_beats, fmt_errors;

  // model and bookkeeping
  logic [line_w-1:0] shadow [0:mem_lines-1];
  logic [ADDR_W-1:0] last_ar_addr;
  logic [ADDR_W-1:0] last_aw_addr;
  integer            seed;
  int                err_count, check_count, tests_passed, tests_failed;
  int                ic_reqs, dc_reqs, ic_acks, dc_acks, rd_issued, wr_issued;
  logic              arb_phase;
  logic              have_prev;
  logic              prev_dc;

  line_xfer_top #(.ADDR_W(ADDR_W)) i_dut (
    .clk(clk), .rst(rst),
    .i_ic_req(i_ic_req), .i_ic_addr(i_ic_addr), .o_ic_ack(o_ic_ack), .o_ic_rdata(o_ic_rdata),
    .i_dc_req(i_dc_req), .i_dc_op(i_dc_op), .i_dc_addr(i_dc_addr), .i_dc_wdata(i_dc_wdata),
    .o_dc_ack(o_dc_ack), .o_dc_rdata(o_dc_rdata),
    .o_ar_valid(ar_valid), .i_ar_ready(ar_ready), .o_ar_addr(ar_addr), .o_ar_len(ar_len),
    .o_ar_size(ar_size), .o_ar_burst(ar_burst),
    .i_r_valid(r_valid), .o_r_ready(r_ready), .i_r_data(r_data), .i_r_last(r_last),
    .o_aw_valid(aw_valid), .i_aw_ready(aw_ready), .o_aw_addr(aw_addr), .o_aw_len(aw_len),
    .o_aw_size(aw_size), .o_aw_burst(aw_burst),
    .o_w_valid(w_valid), .i_w_ready(w_ready), .o_w_data(w_data), .o_w_strb(w_strb),
    .o_w_last(w_last), .i_b_valid(b_valid), .o_b_ready(b_ready)
  );

  axi_mem_slave #(.ADDR_W(ADDR_W), .SEED(seed_init)) i_slave (
    .clk(clk), .rst(rst),
    .i_ar_valid(ar_valid), .o_ar_ready(ar_ready), .i_ar_addr(ar_addr), .i_ar_len(ar_len),
    .i_ar_size(ar_size), .i_ar_burst(ar_burst),
    .o_r_valid(r_valid), .i_r_ready(r_ready), .o_r_data(r_data), .o_r_last(r_last),
    .i_aw_valid(aw_valid), .o_aw_ready(aw_ready), .i_aw_addr(aw_addr), .i_aw_len(aw_len),
    .i_aw_size(aw_size), .i_aw_burst(aw_burst),
    .i_w_valid(w_valid), .o_w_ready(w_ready), .i_w_data(w_data), .i_w_strb(w_strb),
    .i_w_last(w_last), .o_b_valid(b_valid), .i_b_ready(b_ready),
    .o_ar_count(ar_count), .o_aw_count(aw_count), .o_w_beats(w_beats),
    .o_fmt_errors(fmt_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // run limit from the request count
  initial begin
    #(total_reqs * 200 * clk_period);
    $display("watchdog: transfers did not finish within %0d cycles", total_reqs * 200);
    $display("TEST FAIL");
    $finish;
  end

  // initial memory image where every 64-bit word carries its own byte address
  function automatic logic [line_w-1:0] line_pattern(input int unsigned idx);
    logic [line_w-1:0] v;
    logic [31:0]       a;
    int                w;
    for (w = 0; w < beats_per_line; w++) begin
      a = idx * line_bytes + w * 8;
      v[w*beat_w +: beat_w] = {a ^ 32'hc3a5_0000, ~a};
    end
    return v;
  endfunction

  function automatic logic [line_w-1:0] random_line();
    logic [line_w-1:0] v;
    int                k;
    for (k = 0; k < line_w / 32; k++) begin
      v[k*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  // random line in the first n lines with a random unaligned offset
  function automatic logic [ADDR_W-1:0] random_addr(input int lines);
    int unsigned idx;
    logic [5:0]  off;
    idx = $unsigned($random(seed)) % lines;
    off = $random(seed);
    return ADDR_W'(idx * line_bytes) | ADDR_W'(off);
  endfunction

  task automatic compare(input string name, input logic [line_w-1:0] actual,
                         input logic [line_w-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // stays aligned 2 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic ic_refill(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] aligned;
    int unsigned       idx;
    aligned   = addr & ~ADDR_W'(line_bytes - 1);
    idx       = (aligned / line_bytes) % mem_lines;
    i_ic_addr = addr;
    i_ic_req  = 1'b1;
    ic_reqs++;
    rd_issued++;
    @(posedge clk);
    while (!o_ic_ack) @(posedge clk);
    compare("o_ic_rdata", o_ic_rdata, shadow[idx]);
    compare("o_ar_addr", last_ar_addr, aligned);
    #2;
    i_ic_req = 1'b0;
    wait_cycles(1);
  endtask

  task automatic dc_access(input logic op, input logic [ADDR_W-1:0] addr,
                           input logic [line_w-1:0] wdata);
    logic [ADDR_W-1:0] aligned;
    int unsigned       idx;
    aligned    = addr & ~ADDR_W'(line_bytes - 1);
    idx        = (aligned / line_bytes) % mem_lines;
    i_dc_addr  = addr;
    i_dc_op    = op;
    i_dc_wdata = wdata;
    i_dc_req   = 1'b1;
    dc_reqs++;
    if (op == op_write) begin
      wr_issued++;
    end else begin
      rd_issued++;
    end
    @(posedge clk);
    while (!o_dc_ack) @(posedge clk);
    if (op == op_write) begin
      // memory now holds the new line
      shadow[idx] = wdata;
      compare("o_aw_addr", last_aw_addr, aligned);
    end else begin
      compare("o_dc_rdata", o_dc_rdata, shadow[idx]);
      compare("o_ar_addr", last_ar_addr, aligned);
    end
    #2;
    i_dc_req = 1'b0;
    wait_cycles(1);
  endtask

  task automatic run_icache(input int n, input int lines, input int max_idle);
    int i;
    for (i = 0; i < n; i++) begin
      ic_refill(random_addr(lines));
      wait_cycles($unsigned($random(seed)) % (max_idle + 1));
    end
  endtask

  task automatic run_dcache(input int n, input int lines, input int max_idle);
    int   i;
    logic op;
    for (i = 0; i < n; i++) begin
      op = $random(seed);
      dc_access(op, random_addr(lines), random_line());
      wait_cycles($unsigned($random(seed)) % (max_idle + 1));
    end
  endtask

  // bus address capture, ack ownership and alternation
  always @(posedge clk) begin
    if (!rst) begin
      if (ar_valid && ar_ready) begin
        last_ar_addr = ar_addr;
      end
      if (aw_valid && aw_ready) begin
        last_aw_addr = aw_addr;
      end
      if (o_ic_ack) begin
        ic_acks++;
        compare("i_ic_req at o_ic_ack", i_ic_req, 1'b1);
      end
      if (o_dc_ack) begin
        dc_acks++;
        compare("i_dc_req at o_dc_ack", i_dc_req, 1'b1);
      end
      if (arb_phase && (o_ic_ack || o_dc_ack)) begin
        if (have_prev) begin
          compare("o_dc_ack alternation", o_dc_ack, !prev_dc);
        end
        prev_dc   = o_dc_ack;
        have_prev = 1'b1;
      end
    end
  end

  initial begin
    int errs;
    int l;
    i_ic_req     = 1'b0;
    i_ic_addr    = '0;
    i_dc_req     = 1'b0;
    i_dc_op      = op_read;
    i_dc_addr    = '0;
    i_dc_wdata   = '0;
    rst          = 1'b1;
    seed         = seed_init;
    err_count    = 0;
    check_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    ic_reqs      = 0;
    dc_reqs      = 0;
    ic_acks      = 0;
    dc_acks      = 0;
    rd_issued    = 0;
    wr_issued    = 0;
    arb_phase    = 1'b0;
    have_prev    = 1'b0;
    prev_dc      = 1'b0;
    last_ar_addr = '0;
    last_aw_addr = '0;
    for (l = 0; l < mem_lines; l++) begin
      shadow[l] = line_pattern(l);
      i_slave.mem[l] = shadow[l];
    end
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    // quiet bus before any request
    errs = err_count;
    repeat (4) begin
      @(posedge clk);
      compare("o_ic_ack", o_ic_ack, 1'b0);
      compare("o_dc_ack", o_dc_ack, 1'b0);
      compare("o_ar_valid", ar_valid, 1'b0);
      compare("o_aw_valid", aw_valid, 1'b0);
      compare("o_w_valid", w_valid, 1'b0);
      #2;
    end
    report_test("reset", errs);

    errs = err_count;
    run_icache(n_refill, mem_lines, 3);
    report_test("refill", errs);

    // writebacks to a few lines and then icache reads of the same lines
    errs = err_count;
    run_dcache(n_wback, 16, 3);
    run_icache(n_reread, 16, 2);
    report_test("writeback", errs);

    // both caches back to back on shared lines
    errs      = err_count;
    arb_phase = 1'b1;
    have_prev = 1'b0;
    fork
      run_icache(n_arb, 16, 0);
      run_dcache(n_arb, 16, 0);
    join
    arb_phase = 1'b0;
    compare("icache ack count", ic_acks, ic_reqs);
    compare("dcache ack count", dc_acks, dc_reqs);
    report_test("arbitration", errs);

    errs = err_count;
    compare("slave format errors", fmt_errors, 0);
    compare("AR burst count", ar_count, rd_issued);
    compare("AW burst count", aw_count, wr_issued);
    compare("W beat count", w_beats, 8 * wr_issued);
    report_test("burst format", errs);

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, check_count, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
